//--- src/corr_defs.svh
`ifndef CORR_DEFS_SVH
`define CORR_DEFS_SVH

// ------------------------------------------------
// Correlator sizing
// ------------------------------------------------

// Antennas, also the width of the re and im sample words
`define NUM_ANTENNA 8

// Signed width of one accumulator component
`define ACCUM_BITS  16

// Time slots per sample in each lane
`define TRATE       4
`define TBITS       2           // Slot address width, log2 of TRATE

// Correlator lanes sharing the sample bus
`define NUM_LANES   2

`endif

//--- src/corr_pkg.sv
`include "corr_defs.svh"

package corr_pkg;

   // One strobed sample, one bit per antenna and component
   typedef struct packed {
      logic [`NUM_ANTENNA-1:0] re;
      logic [`NUM_ANTENNA-1:0] im;
   } sample_t;

   // Antenna pair for one slot
   typedef struct packed {
      logic [2:0] a;
      logic [2:0] b;
   } pair_t;

   // Visibility word, im in the upper half and re in the lower half
   typedef struct packed {
      logic signed [`ACCUM_BITS-1:0] im;
      logic signed [`ACCUM_BITS-1:0] re;
   } vis_t;

   // ------------------------------------------------
   // Correlation rule
   //   Bit 1 is +1, bit 0 is -1
   //   re += re_a*re_b + im_a*im_b
   //   im += im_a*re_b - re_a*im_b
   //   Each increment is -2, 0 or +2, sums wrap mod 2^16
   // ------------------------------------------------

   // Pair per lane and slot
   localparam pair_t PAIR_TABLE [`NUM_LANES][`TRATE] = '{
      '{'{3'd0, 3'd1}, '{3'd0, 3'd2}, '{3'd0, 3'd3}, '{3'd1, 3'd2}},  // Lane 0
      '{'{3'd1, 3'd3}, '{3'd2, 3'd3}, '{3'd4, 3'd5}, '{3'd6, 3'd7}}   // Lane 1
   };

endpackage

//--- src/corr_if.sv
`timescale 1ns/1ns
`include "corr_defs.svh"

// ------------------------------------------------
// Sequencer to lanes
// ------------------------------------------------
interface slot_if;
   import corr_pkg::*;

   sample_t            sample;     // Held for the whole sweep
   logic               rd_valid;   // Read side of the RMW pass
   logic [`TBITS-1:0]  rd_slot;
   logic               wr_valid;   // Write side, one cycle behind
   logic [`TBITS-1:0]  wr_slot;
   logic               clear;      // Sweep starts every accumulator at zero

   modport seq  (output sample, rd_valid, rd_slot, wr_valid, wr_slot, clear);
   modport lane (input  sample, rd_valid, rd_slot, wr_valid, wr_slot, clear);
endinterface

// ------------------------------------------------
// Lanes to visibility buffer
// ------------------------------------------------
interface vis_if;
   import corr_pkg::*;

   logic [`NUM_LANES-1:0] we;         // One strobe per lane
   logic [`TBITS-1:0]     slot;       // Shared write slot
   logic                  bank;       // Active write bank
   vis_t                  data [`NUM_LANES];

   // Each lane drives only its own we and data element
   modport lane   (output we, slot, data, input bank);
   modport buffer (input  we, slot, data, bank);
endinterface

//--- src/corr_sequencer.sv
`timescale 1ns/1ns
`include "corr_defs.svh"

module corr_sequencer (
   input  logic                    clk_x,
   input  logic                    rst,
   input  logic                    en_i,    // Sample strobe
   input  logic                    sw_i,    // Bank switch request
   input  logic [`NUM_ANTENNA-1:0] re_i,
   input  logic [`NUM_ANTENNA-1:0] im_i,
   output logic                    bank_o,  // Active write bank
   slot_if.seq                     sl
);

   logic pending;     // Swap requested, waiting for a sample
   logic swap_now;
   logic last_rd;
   logic last_wr;

   // A request in the same cycle as the strobe counts too
   assign swap_now = en_i && (pending || sw_i);
   assign last_rd  = sl.rd_valid && (sl.rd_slot == `TBITS'(`TRATE-1));
   assign last_wr  = sl.wr_valid && (sl.wr_slot == `TBITS'(`TRATE-1));

   // ------------------------------------------------
   // Sample capture
   // ------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (en_i) begin
         sl.sample <= '{re: re_i, im: im_i};
      end
   end

   // ------------------------------------------------
   // Slot counters
   // ------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         sl.rd_valid <= 1'b0;
         sl.rd_slot  <= '0;
         sl.wr_valid <= 1'b0;
         sl.wr_slot  <= '0;
      end else begin
         if (en_i) begin
            sl.rd_valid <= 1'b1;          // Sweep starts with slot 0
            sl.rd_slot  <= '0;
         end else if (sl.rd_valid) begin
            sl.rd_valid <= !last_rd;
            sl.rd_slot  <= sl.rd_slot + 1'b1;
         end
         // Write side trails the read side by one cycle
         sl.wr_valid <= sl.rd_valid;
         sl.wr_slot  <= sl.rd_slot;
      end
   end

   // ------------------------------------------------
   // Swap, bank and clear state
   // ------------------------------------------------
   always_ff @(posedge clk_x) begin
      if (rst) begin
         pending  <= 1'b0;
         bank_o   <= 1'b0;
         sl.clear <= 1'b1;               // First sample starts from zero
      end else begin
         if (swap_now) begin
            pending  <= 1'b0;
            bank_o   <= !bank_o;         // Flip on the accepted strobe
            sl.clear <= 1'b1;            // Held through this sweep
         end else begin
            if (sw_i) begin
               pending <= 1'b1;          // Repeats merge into one
            end
            if (last_wr) begin
               sl.clear <= 1'b0;         // Sweep done, accumulate from now on
            end
         end
      end
   end

endmodule

//--- src/correlator_lane.sv
`timescale 1ns/1ns
`include "corr_defs.svh"

module correlator_lane #(
   parameter int LANE = 0             // Row of the pair table
) (
   input  logic clk_x,
   input  logic rst,
   slot_if.lane sl,
   vis_if.lane  vis
);
   import corr_pkg::*;

   pair_t                    pair;
   logic                     ra, ia, rb, ib;
   logic signed [2:0]        inc_re, inc_im;
   logic signed [2:0]        inc_re_q, inc_im_q;
   vis_t                     acc_mem [`TRATE];  // Running accumulators
   vis_t                     acc_q;
   vis_t                     sum;
   logic                     vld_q;             // Read stage result valid
   logic                     we;

   // Two +-1 products into -2, 0 or +2, where x and y are
   // true for a +1 product
   function automatic logic signed [2:0] pair_sum(input logic x, input logic y);
      logic signed [2:0] s;
      if (x && y)
         s = 3'sd2;
      else if (!x && !y)
         s = -3'sd2;
      else
         s = 3'sd0;
      return s;
   endfunction

   // ------------------------------------------------
   // Read stage, pair lookup and products
   // ------------------------------------------------
   assign pair = PAIR_TABLE[LANE][sl.rd_slot];
   assign ra   = sl.sample.re[pair.a];
   assign ia   = sl.sample.im[pair.a];
   assign rb   = sl.sample.re[pair.b];
   assign ib   = sl.sample.im[pair.b];

   // Equal bits give +1
   assign inc_re = pair_sum(ra ~^ rb, ia ~^ ib);
   assign inc_im = pair_sum(ia ~^ rb, ra ^ ib);   // Second term negated

   always_ff @(posedge clk_x) begin
      if (sl.rd_valid) begin
         acc_q    <= acc_mem[sl.rd_slot];
         inc_re_q <= inc_re;
         inc_im_q <= inc_im;
      end
   end

   always_ff @(posedge clk_x) begin
      if (rst)
         vld_q <= 1'b0;
      else
         vld_q <= sl.rd_valid;
   end

   // ------------------------------------------------
   // Write stage
   // ------------------------------------------------
   // Clear swaps the stored value for zero, sum wraps at 16 bits
   assign sum.re = (sl.clear ? '0 : acc_q.re) + `ACCUM_BITS'(inc_re_q);
   assign sum.im = (sl.clear ? '0 : acc_q.im) + `ACCUM_BITS'(inc_im_q);
   assign we     = vld_q && sl.wr_valid;

   always_ff @(posedge clk_x) begin
      if (we) begin
         acc_mem[sl.wr_slot] <= sum;
      end
   end

   // Buffer captures on the same edge as the accumulator
   assign vis.we[LANE]   = we;
   assign vis.data[LANE] = sum;

   // Slots are common to all lanes, lane 0 drives the copy
   generate
      if (LANE == 0) begin : g_slot
         assign vis.slot = sl.wr_slot;
      end
   endgenerate

endmodule

//--- src/vis_buffer.sv
`timescale 1ns/1ns
`include "corr_defs.svh"

module vis_buffer (
   input  logic                   clk_x,
   input  logic                   rst,
   input  logic                   cyc_i,
   input  logic                   stb_i,
   input  logic [3:0]             adr_i,   // {lane, slot, component}
   output logic                   ack_o,
   output logic [`ACCUM_BITS-1:0] dat_o,
   vis_if.buffer                  vis
);
   import corr_pkg::*;

   localparam int NVIS = `NUM_LANES * `TRATE;

   vis_t       mem [2][NVIS];   // Bank, then lane*TRATE + slot
   logic       req;
   logic       req_q;            // Request seen last edge
   logic       ack_q;
   logic [3:0] adr_q;
   logic       half_q;           // Component select for dat_o
   vis_t       rd_word;

   // ------------------------------------------------
   // Write side, every lane in the same cycle
   // ------------------------------------------------
   always_ff @(posedge clk_x) begin
      for (int l = 0; l < `NUM_LANES; l++) begin
         if (vis.we[l]) begin
            mem[vis.bank][l*`TRATE + int'(vis.slot)] <= vis.data[l];
         end
      end
   end

   // ------------------------------------------------
   // Bus read path
   // ------------------------------------------------
   assign req = cyc_i && stb_i;

   always_ff @(posedge clk_x) begin
      if (req) begin
         adr_q <= adr_i;                       // Edge k
      end
      rd_word <= mem[!vis.bank][adr_q[3:1]];   // Edge k+1, inactive bank only
      half_q  <= adr_q[0];
      dat_o   <= half_q ? rd_word.im : rd_word.re;  // Edge k+2
   end

   // Acknowledge, dropped if cyc_i falls straight after the strobe
   always_ff @(posedge clk_x) begin
      if (rst) begin
         req_q <= 1'b0;
         ack_q <= 1'b0;
         ack_o <= 1'b0;
      end else begin
         req_q <= req;
         ack_q <= req_q && cyc_i;
         ack_o <= ack_q;
      end
   end

endmodule

//--- src/correlator_block.sv
`timescale 1ns/1ns
`include "corr_defs.svh"

module correlator_block (
   input  logic                    clk_x,
   input  logic                    rst,

   // Antenna samples
   input  logic                    en_i,
   input  logic                    sw_i,
   input  logic [`NUM_ANTENNA-1:0] re_i,
   input  logic [`NUM_ANTENNA-1:0] im_i,

   // Visibility read bus
   input  logic                    cyc_i,
   input  logic                    stb_i,
   input  logic [3:0]              adr_i,
   output logic                    ack_o,
   output logic [`ACCUM_BITS-1:0]  dat_o,

   output logic                    bank_o
);

   slot_if sl ();
   vis_if  vis ();

   // Buffer writes go to the bank the sequencer holds
   assign vis.bank = bank_o;

   // ------------------------------------------------
   // Input side
   // ------------------------------------------------
   corr_sequencer u_seq (
      .clk_x  (clk_x),
      .rst    (rst),
      .en_i   (en_i),
      .sw_i   (sw_i),
      .re_i   (re_i),
      .im_i   (im_i),
      .bank_o (bank_o),
      .sl     (sl)
   );

   // ------------------------------------------------
   // Lanes
   // ------------------------------------------------
   correlator_lane #(.LANE(0)) u_lane0 (
      .clk_x (clk_x),
      .rst   (rst),
      .sl    (sl),
      .vis   (vis)
   );

   correlator_lane #(.LANE(1)) u_lane1 (
      .clk_x (clk_x),
      .rst   (rst),
      .sl    (sl),
      .vis   (vis)
   );

   // Output side
   vis_buffer u_buf (
      .clk_x (clk_x),
      .rst   (rst),
      .cyc_i (cyc_i),
      .stb_i (stb_i),
      .adr_i (adr_i),
      .ack_o (ack_o),
      .dat_o (dat_o),
      .vis   (vis)
   );

endmodule

//--- sim/correlator_block_properties.sv
`timescale 1ns/1ns

module correlator_block_properties (
   input logic clk_x,
   input logic rst,
   input logic en_i,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_o,
   input logic bank_o
);

   int unsigned since_en;    // Saturating count of cycles since the last strobe
   int          fail_count;

   always_ff @(posedge clk_x) begin
      if (rst)
         since_en <= 100;
      else if (en_i)
         since_en <= 1;
      else if (since_en < 100)
         since_en <= since_en + 1;
   end

   // Strobes at least 6 cycles apart
   en_spacing: assert property (@(posedge clk_x) disable iff (rst) en_i |-> since_en >= 6)
      else begin
         fail_count++;
         $error("sample strobes closer than 6 cycles");
      end

   // Rise is seen one edge late so the request lies three samples back
   ack_delay: assert property (@(posedge clk_x) disable iff (rst)
                               $rose(ack_o) |-> $past(cyc_i && stb_i, 3))
      else begin
         fail_count++;
         $error("ack_o rose without a request 2 cycles before");
      end

   bank_flip: assert property (@(posedge clk_x) disable iff (rst)
                               $changed(bank_o) |-> $past(en_i))
      else begin
         fail_count++;
         $error("bank_o changed without a sample strobe");
      end

endmodule

bind correlator_block correlator_block_properties u_props (
   .clk_x  (clk_x),
   .rst    (rst),
   .en_i   (en_i),
   .cyc_i  (cyc_i),
   .stb_i  (stb_i),
   .ack_o  (ack_o),
   .bank_o (bank_o)
);

//--- sim/tb_correlator_block.sv
`timescale 1ns/1ns
`include "corr_defs.svh"

module tb_correlator_block;

   localparam int N_INTEG   = 2;
   localparam int N_SAMPLES = 40;
   localparam int N_READS   = 16 * N_INTEG + N_SAMPLES + 2;  // Concurrent reads budgeted too
   localparam int LIMIT     = N_INTEG * N_SAMPLES * 8 + N_READS * 4 + 200;

   logic                    clk_x, rst;
   logic                    en_i, sw_i;
   logic [`NUM_ANTENNA-1:0] re_i, im_i;
   logic                    cyc_i, stb_i;
   logic [3:0]              adr_i;
   logic                    ack_o;
   logic [`ACCUM_BITS-1:0]  dat_o;
   logic                    bank_o;

   int errors;
   int acc_re [2][8];      // Model totals per bank and visibility
   int acc_im [2][8];
   bit m_bank;
   bit m_pending;
   bit sampling;           // Sample stream still running

   correlator_block UUT (.*);

   initial begin
      clk_x = 1'b0;
      forever #4 clk_x = ~clk_x;
   end

   // ------------------------------------------------
   // Reference model
   // ------------------------------------------------
   // Antennas of visibility v
   function automatic int ant_a(input int v);
      case (v)
         0, 1, 2: return 0;
         3, 4:    return 1;
         5:       return 2;
         6:       return 4;
         default: return 6;
      endcase
   endfunction

   function automatic int ant_b(input int v);
      case (v)
         0:       return 1;
         1, 3:    return 2;
         2, 4, 5: return 3;
         6:       return 5;
         default: return 7;
      endcase
   endfunction

   function automatic int pm(input logic b);
      return b ? 1 : -1;             // Bit 1 is +1
   endfunction

   task automatic model_sample(input logic [7:0] r, input logic [7:0] i);
      int a, b;
      if (m_pending) begin           // Accepted strobe takes the swap
         m_bank    = ~m_bank;
         m_pending = 1'b0;
         for (int v = 0; v < 8; v++) begin
            acc_re[m_bank][v] = 0;
            acc_im[m_bank][v] = 0;
         end
      end
      for (int v = 0; v < 8; v++) begin
         a = ant_a(v);
         b = ant_b(v);
         acc_re[m_bank][v] += pm(r[a]) * pm(r[b]) + pm(i[a]) * pm(i[b]);
         acc_im[m_bank][v] += pm(i[a]) * pm(r[b]) - pm(r[a]) * pm(i[b]);
      end
   endtask

   task automatic log_error(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   // ------------------------------------------------
   // Stimulus on the falling edge
   // ------------------------------------------------
   task automatic send_sample(input int idle);
      logic [7:0] r, i;
      r = 8'($urandom);
      i = 8'($urandom);
      @(negedge clk_x);
      en_i = 1'b1;
      re_i = r;
      im_i = i;
      model_sample(r, i);
      @(negedge clk_x);
      en_i = 1'b0;
      repeat (idle - 1) @(negedge clk_x);   // Strobes idle+1 cycles apart
      if (bank_o !== m_bank)
         log_error($sformatf("error at %0t ns: bank_o %b, expected %b", $time, bank_o, m_bank));
   endtask

   task automatic pulse_switch();
      @(negedge clk_x);
      sw_i      = 1'b1;
      m_pending = 1'b1;
      @(negedge clk_x);
      sw_i      = 1'b0;
   endtask

   task automatic read_word(input logic [3:0] adr, output logic [15:0] data);
      int lat;
      @(negedge clk_x);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      adr_i = adr;
      @(negedge clk_x);
      stb_i = 1'b0;                  // One-cycle strobe
      lat   = 1;
      while (!ack_o && lat < 10) begin
         @(negedge clk_x);
         lat++;
      end
      data  = dat_o;
      cyc_i = 1'b0;
      if (!ack_o)
         log_error($sformatf("no acknowledge for the read of address %0d", adr));
      else if (lat != 3)
         log_error($sformatf("error at %0t ns: ack after %0d cycles, expected 2", $time, lat - 1));
      @(negedge clk_x);
      if (ack_o)
         log_error($sformatf("acknowledge for address %0d lasted more than one cycle", adr));
   endtask

   task automatic check_word(input logic [3:0] adr, input bit bank, input logic [15:0] got);
      logic [15:0] exp;
      int          v;
      v   = int'(adr[3:1]);
      exp = adr[0] ? 16'(acc_im[bank][v]) : 16'(acc_re[bank][v]);
      if (got !== exp)
         log_error($sformatf("error at %0t ns: bank %0d vis %0d %s got %0d expected %0d",
                             $time, bank, v, adr[0] ? "im" : "re", $signed(got), $signed(exp)));
   endtask

   task automatic read_bank(input bit bank);
      logic [15:0] d;
      for (int a = 0; a < 16; a++) begin
         read_word(4'(a), d);
         check_word(4'(a), bank, d);
      end
   endtask

   // ------------------------------------------------
   // Test sequence
   // ------------------------------------------------
   initial begin
      logic [15:0] d;
      logic [3:0]  a;
      void'($urandom(32'h594d_4f2a));
      errors    = 0;
      m_bank    = 1'b0;
      m_pending = 1'b0;
      sampling  = 1'b0;
      rst   = 1'b1;
      en_i  = 1'b0;
      sw_i  = 1'b0;
      re_i  = '0;
      im_i  = '0;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      adr_i = '0;
      repeat (8) @(negedge clk_x);
      rst = 1'b0;
      if (ack_o !== 1'b0)
         log_error($sformatf("error at %0t ns: ack_o %b after reset", $time, ack_o));
      if (bank_o !== 1'b0)
         log_error($sformatf("error at %0t ns: bank_o %b after reset", $time, bank_o));

      repeat (N_SAMPLES) send_sample(5 + $urandom % 3);    // First integration into bank 0
      pulse_switch();
      send_sample(6);
      if (bank_o !== 1'b1)
         log_error($sformatf("error at %0t ns: bank_o %b after swap", $time, bank_o));
      read_bank(1'b0);

      // Second integration while the finished bank is read
      sampling = 1'b1;
      fork
         begin
            repeat (N_SAMPLES - 1) send_sample(5 + $urandom % 3);
            sampling = 1'b0;
         end
         while (sampling) begin
            a = 4'($urandom);
            read_word(a, d);
            check_word(a, 1'b0, d);
         end
      join

      pulse_switch();                // Second request merges with the first
      repeat (2) @(negedge clk_x);
      pulse_switch();
      send_sample(6);
      send_sample(6);                // No swap left pending
      read_bank(1'b1);

      // Strobe dropped with cyc_i right away
      @(negedge clk_x);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      adr_i = 4'd5;
      @(negedge clk_x);
      cyc_i = 1'b0;
      stb_i = 1'b0;
      repeat (6) begin
         @(negedge clk_x);
         if (ack_o)
            log_error("acknowledge given to a request that cyc_i dropped");
      end
      read_word(4'd3, d);
      check_word(4'd3, 1'b1, d);

      $display("checks done, %0d errors, %0d assertion failures",
               errors, UUT.u_props.fail_count);
      if (errors == 0 && UUT.u_props.fail_count == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   // Watchdog
   initial begin
      repeat (LIMIT) @(posedge clk_x);
      $display("timeout, the run did not finish within %0d cycles", LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

//--- build.f
+incdir+src
src/corr_pkg.sv
src/corr_if.sv
src/corr_sequencer.sv
src/correlator_lane.sv
src/vis_buffer.sv
src/correlator_block.sv
sim/correlator_block_properties.sv
sim/tb_correlator_block.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run, status follows the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_correlator_block -f build.f \
   && ./obj_dir/Vtb_correlator_block +verilator+error+limit+100 | tee /dev/stderr \
      | grep -qF "Simulation finished: PASS" \
   && echo "simulation run passed" \
   || { echo "simulation run failed"; exit 1; }
